// ==== include/vma_defs.svh ====
// Word widths and microword/VMA field positions; include in any file that slices these words
`ifndef VMA_DEFS_SVH
`define VMA_DEFS_SVH

//////////////////////////////////////////////////
// Word widths
//////////////////////////////////////////////////

`define WORD_W      36
`define ADDR_W      23
`define UWORD_W     24

//////////////////////////////////////////////////
// Microword fields
//////////////////////////////////////////////////

// Memory control group
`define U_MEMCYCLE  0
`define U_LOADVMA   1
`define U_AREAD     2
`define U_WAIT      3
`define U_BWRITE    4
`define U_DPFUNC    5
`define U_FORCEUSER 6
`define U_FORCEEXEC 7
`define U_FETCH     8
`define U_PHYS      9
`define U_EXTD      10

// Cycle type requested by the microcode
`define U_READ      11
`define U_WRTEST    12
`define U_WRITE     13
`define U_CACHEINH  14

// Special function group, bits 23:19 spare
`define U_SPECEN    15
`define U_SPECSEL   18:16

//////////////////////////////////////////////////
// Data-path word and VMA layout
//////////////////////////////////////////////////

// Address in the low bits
`define D_ADDR      22:0
`define D_EXTD      23
// Cycle type
`define D_CACHEINH  24
`define D_WRITE     25
`define D_WRTEST    26
`define D_READ      27
// Reference flags, also the PC flag positions on a flag load
`define D_IOBYTE    28
`define D_VECT      29
`define D_WRU       30
`define D_IO        31
`define D_PREV      32
`define D_PHYS      33
`define D_FETCH     34
`define D_USER      35

`endif

// ==== hw/vmaPkg.sv ====
// Enum types for the VMA front end; pulled in by wildcard import in each module header
package vmaPkg;

   // Special function select, meaningful only with the enable bit
   typedef enum logic [2:0] {
      specNone     = 3'd0,
      specClrCache = 3'd1,
      specPrevious = 3'd2,
      specRsvd3    = 3'd3,
      specRsvd4    = 3'd4,
      specRsvd5    = 3'd5,
      specRsvd6    = 3'd6,
      specRsvd7    = 3'd7
   } specFunc_t;

   // Where the VMA flag fields come from
   typedef enum logic {
      fieldFromDp    = 1'b0,
      fieldFromMicro = 1'b1
   } fieldSrc_t;

   // Where the read/write-test/write/cache-inhibit bits come from
   typedef enum logic [1:0] {
      cycleFromDispatch = 2'd0,
      cycleFromDp       = 2'd1,
      cycleFromMicro    = 2'd2
   } cycleSrc_t;

   // Opcode class, top three opcode bits
   typedef enum logic [2:0] {
      opNoMem     = 3'd0,
      opRead      = 3'd1,
      opReadWrite = 3'd2,
      opWrite     = 3'd3,
      opImmediate = 3'd4,
      opJump      = 3'd5,
      opIo        = 3'd6,
      opSpecial   = 3'd7
   } opClass_t;

endpackage

// ==== hw/microDecode.sv ====
// Microword decode; turns the memory control group into VMA load enables and source selects
`timescale 1ns/100ps

`include "vma_defs.svh"

module microDecode
   import vmaPkg::*;
(
   input  logic [`UWORD_W-1:0] microWord,
   input  logic                dromVma,
   input  logic                dromWrite,
   // Load qualifiers
   output logic                vmaEn,
   output logic                memEn,
   // Source selects
   output fieldSrc_t           fieldSrc,
   output cycleSrc_t           cycleSrc,
   output logic                selPrevious,
   // Reference modifiers
   output logic                forceUser,
   output logic                forceExec,
   output logic                fetchCycle,
   output logic                physCycle,
   output logic                extAddr,
   // Microcode cycle bits
   output logic                microRead,
   output logic                microWrTest,
   output logic                microWrite,
   output logic                microCacheInh
);

   //////////////////////////////////////////////////
   // Field extraction
   //////////////////////////////////////////////////

   logic      memCycle;
   logic      loadVma;
   logic      aRead;
   logic      memWait;
   logic      bWrite;
   logic      dpFunc;
   logic      specEn;
   specFunc_t specFunc;
   logic      clrCache;

   assign memCycle = microWord[`U_MEMCYCLE];
   assign loadVma  = microWord[`U_LOADVMA];
   assign aRead    = microWord[`U_AREAD];
   assign memWait  = microWord[`U_WAIT];
   assign bWrite   = microWord[`U_BWRITE];
   assign dpFunc   = microWord[`U_DPFUNC];
   assign specEn   = microWord[`U_SPECEN];

   // Select field ignored unless enabled
   assign specFunc = specEn ? specFunc_t'(microWord[`U_SPECSEL]) : specNone;

   // Cache sweep and previous context share one field, so never both
   assign clrCache    = (specFunc == specClrCache);
   assign selPrevious = (specFunc == specPrevious);

   //////////////////////////////////////////////////
   // Load qualifiers
   //////////////////////////////////////////////////

   // Explicit load, dispatch A-read load, or cache sweep
   assign vmaEn = (memCycle & loadVma) | (memCycle & aRead & dromVma) | clrCache;

   // Cycle control start, or conditional write from dispatch
   assign memEn = (memCycle & memWait) | (memCycle & bWrite & dromWrite);

   // Flags from data path on a dp function
   assign fieldSrc = dpFunc ? fieldFromDp : fieldFromMicro;

   // A-read wins over dp function
   always_comb
   begin
      if (aRead)
         cycleSrc = cycleFromDispatch;
      else if (dpFunc)
         cycleSrc = cycleFromDp;
      else
         cycleSrc = cycleFromMicro;
   end

   // Straight microword controls
   assign forceUser     = microWord[`U_FORCEUSER];
   assign forceExec     = microWord[`U_FORCEEXEC];
   assign fetchCycle    = microWord[`U_FETCH];
   assign physCycle     = microWord[`U_PHYS];
   assign extAddr       = microWord[`U_EXTD];
   assign microRead     = microWord[`U_READ];
   assign microWrTest   = microWord[`U_WRTEST];
   assign microWrite    = microWord[`U_WRITE];
   assign microCacheInh = microWord[`U_CACHEINH];

endmodule

// ==== hw/dispatchRom.sv ====
// Dispatch table by opcode class; gives the memory cycle type and VMA-load permission
`timescale 1ns/100ps

module dispatchRom
   import vmaPkg::*;
(
   input  logic [8:0] opcode,
   output logic       dromRead,
   output logic       dromWrTest,
   output logic       dromWrite,
   output logic       dromVma
);

   //////////////////////////////////////////////////
   // Class decode
   //////////////////////////////////////////////////

   // Low six bits pick an instruction within the class
   // and do not change its memory behaviour
   opClass_t   opClass;
   logic [3:0] romEntry;

   assign opClass = opClass_t'(opcode[8:6]);

   //////////////////////////////////////////////////
   // Table
   //////////////////////////////////////////////////

   // Entry layout {read, wrtest, write, vma}
   always_comb
   begin
      case (opClass)
         // Plain operand fetch
         opRead:      romEntry = 4'b1001;
         // Read-modify-write, test writability on the read
         opReadWrite: romEntry = 4'b1101;
         // Store only
         opWrite:     romEntry = 4'b0011;
         // IO read, address comes from elsewhere
         opIo:        romEntry = 4'b1000;
         // Jump target goes to VMA, no cycle
         opJump:      romEntry = 4'b0001;
         // No memory reference
         opNoMem:     romEntry = 4'b0000;
         opImmediate: romEntry = 4'b0000;
         opSpecial:   romEntry = 4'b0000;
         default:     romEntry = 4'b0000;
      endcase
   end

   assign dromRead   = romEntry[3];
   assign dromWrTest = romEntry[2];
   assign dromWrite  = romEntry[1];
   assign dromVma    = romEntry[0];

endmodule

// ==== hw/pcFlags.sv ====
// PC user and previous-context-user flags; loaded from the data path or swapped on a context switch
`timescale 1ns/100ps

`include "vma_defs.svh"

module pcFlags
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   // Strobes
   input  logic               flagLoad,
   input  logic               ctxSwitch,
   // Data path word
   input  logic [`WORD_W-1:0] dp,
   // Current flags
   output logic               flagUser,
   output logic               flagPcu
);

   //////////////////////////////////////////////////
   // Flag register
   //////////////////////////////////////////////////

   // Flag load takes priority over context switch
   // PCU is taken from the prev bit position of the word
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         flagUser <= 1'b0;
         flagPcu  <= 1'b0;
      end
      else if (clken)
      begin
         if (flagLoad)
         begin
            flagUser <= dp[`D_USER];
            flagPcu  <= dp[`D_PREV];
         end
         else if (ctxSwitch)
         begin
            // Old mode becomes previous context, now executive
            flagPcu  <= flagUser;
            flagUser <= 1'b0;
         end
      end
   end

endmodule

// ==== hw/vmaRegister.sv ====
// VMA address, reference flags and cycle-control register with its one-cycle load pulse
`timescale 1ns/100ps

`include "vma_defs.svh"

module vmaRegister
   import vmaPkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  logic               pageFail,
   input  logic               cpuExec,
   input  logic               prevEn,
   input  logic [`WORD_W-1:0] dp,
   // From microword decode
   input  logic               vmaEn,
   input  logic               memEn,
   input  fieldSrc_t          fieldSrc,
   input  cycleSrc_t          cycleSrc,
   input  logic               selPrevious,
   input  logic               forceUser,
   input  logic               forceExec,
   input  logic               fetchCycle,
   input  logic               physCycle,
   input  logic               extAddr,
   input  logic               microRead,
   input  logic               microWrTest,
   input  logic               microWrite,
   input  logic               microCacheInh,
   // From dispatch table
   input  logic               dromRead,
   input  logic               dromWrTest,
   input  logic               dromWrite,
   // From PC flags
   input  logic               flagUser,
   input  logic               flagPcu,
   output logic [`WORD_W-1:0] vmaReg,
   output logic               vmaLoad
);

   logic [`ADDR_W-1:0] vmaAddr;
   logic               vmaExtd;
   logic               vmaUser, vmaFetch, vmaPhys, vmaPrev;
   logic               vmaIo, vmaWru, vmaVect, vmaIoByte;
   logic               vmaRead, vmaWrTest, vmaWrite, vmaCacheInh;
   logic               userSel;
   logic [3:0]         nextCycle;

   //////////////////////////////////////////////////
   // Address and flag fields
   //////////////////////////////////////////////////

   // User mode selection for microcode-built references
   assign userSel = (~forceExec & flagUser & ~cpuExec) | (fetchCycle & flagUser) |
                    (prevEn & flagPcu) | (selPrevious & flagPcu) | forceUser;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vmaAddr   <= '0;
         vmaExtd   <= 1'b0;
         vmaUser   <= 1'b0;
         vmaFetch  <= 1'b0;
         vmaPhys   <= 1'b0;
         vmaPrev   <= 1'b0;
         vmaIo     <= 1'b0;
         vmaWru    <= 1'b0;
         vmaVect   <= 1'b0;
         vmaIoByte <= 1'b0;
      end
      // Page fail freezes the faulting address
      else if (clken & vmaEn & ~pageFail)
      begin
         vmaAddr <= dp[`D_ADDR];
         vmaExtd <= extAddr;
         if (fieldSrc == fieldFromDp)
         begin
            vmaUser   <= dp[`D_USER];
            vmaFetch  <= dp[`D_FETCH];
            vmaPhys   <= dp[`D_PHYS];
            vmaPrev   <= dp[`D_PREV];
            vmaIo     <= dp[`D_IO];
            vmaWru    <= dp[`D_WRU];
            vmaVect   <= dp[`D_VECT];
            vmaIoByte <= dp[`D_IOBYTE];
         end
         else
         begin
            vmaUser   <= userSel;
            vmaFetch  <= fetchCycle;
            vmaPhys   <= physCycle;
            vmaPrev   <= prevEn | selPrevious;
            // Never an IO reference from microcode
            vmaIo     <= 1'b0;
            vmaWru    <= 1'b0;
            vmaVect   <= 1'b0;
            vmaIoByte <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // Cycle control
   //////////////////////////////////////////////////

   // {read, wrtest, write, cacheinh}, dispatch never inhibits cache
   always_comb
   begin
      case (cycleSrc)
         cycleFromDispatch: nextCycle = {dromRead, dromWrTest, dromWrite, 1'b0};
         cycleFromDp:       nextCycle = {dp[`D_READ], dp[`D_WRTEST], dp[`D_WRITE],
                                         dp[`D_CACHEINH]};
         default:           nextCycle = {microRead, microWrTest, microWrite, microCacheInh};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         {vmaRead, vmaWrTest, vmaWrite, vmaCacheInh} <= 4'b0000;
      else if (clken & memEn & ~pageFail)
         {vmaRead, vmaWrTest, vmaWrite, vmaCacheInh} <= nextCycle;
   end

   // Load pulse, raw enable delayed one clock
   always_ff @(posedge clk)
   begin
      if (rst)
         vmaLoad <= 1'b0;
      else
         vmaLoad <= vmaEn;
   end

   // Pack fields into the shared word layout
   always_comb
   begin
      vmaReg              = '0;
      vmaReg[`D_ADDR]     = vmaAddr;
      vmaReg[`D_EXTD]     = vmaExtd;
      vmaReg[`D_USER]     = vmaUser;
      vmaReg[`D_FETCH]    = vmaFetch;
      vmaReg[`D_PHYS]     = vmaPhys;
      vmaReg[`D_PREV]     = vmaPrev;
      vmaReg[`D_IO]       = vmaIo;
      vmaReg[`D_WRU]      = vmaWru;
      vmaReg[`D_VECT]     = vmaVect;
      vmaReg[`D_IOBYTE]   = vmaIoByte;
      vmaReg[`D_READ]     = vmaRead;
      vmaReg[`D_WRTEST]   = vmaWrTest;
      vmaReg[`D_WRITE]    = vmaWrite;
      vmaReg[`D_CACHEINH] = vmaCacheInh;
   end

endmodule

// ==== hw/memAddrUnit.sv ====
// Top of the VMA front end; wires microword decode, dispatch table, PC flags and VMA register
`timescale 1ns/100ps

`include "vma_defs.svh"

module memAddrUnit
   import vmaPkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                clken,
   input  logic [`UWORD_W-1:0] microWord,
   input  logic [8:0]          opcode,
   input  logic [`WORD_W-1:0]  dp,
   input  logic                cpuExec,
   input  logic                prevEn,
   input  logic                pageFail,
   input  logic                flagLoad,
   input  logic                ctxSwitch,
   output logic [`WORD_W-1:0]  vmaReg,
   output logic                vmaLoad
);

   //////////////////////////////////////////////////
   // Internal nets
   //////////////////////////////////////////////////

   // Decode outputs
   logic      vmaEn, memEn, selPrevious;
   fieldSrc_t fieldSrc;
   cycleSrc_t cycleSrc;
   logic      forceUser, forceExec, fetchCycle, physCycle, extAddr;
   logic      microRead, microWrTest, microWrite, microCacheInh;
   // Dispatch outputs
   logic      dromRead, dromWrTest, dromWrite, dromVma;
   // PC flags
   logic      flagUser, flagPcu;

   // Control
   microDecode u_microDecode (.microWord, .dromVma, .dromWrite, .vmaEn, .memEn,
                              .fieldSrc, .cycleSrc, .selPrevious, .forceUser,
                              .forceExec, .fetchCycle, .physCycle, .extAddr,
                              .microRead, .microWrTest, .microWrite, .microCacheInh);

   // Opcode class lookup
   dispatchRom u_dispatchRom (.opcode, .dromRead, .dromWrTest, .dromWrite, .dromVma);

   // Mode flags
   pcFlags u_pcFlags (.clk, .rst, .clken, .flagLoad, .ctxSwitch, .dp,
                      .flagUser, .flagPcu);

   // Address register
   vmaRegister u_vmaRegister (.clk, .rst, .clken, .pageFail, .cpuExec, .prevEn, .dp,
                              .vmaEn, .memEn, .fieldSrc, .cycleSrc, .selPrevious,
                              .forceUser, .forceExec, .fetchCycle, .physCycle,
                              .extAddr, .microRead, .microWrTest, .microWrite,
                              .microCacheInh, .dromRead, .dromWrTest, .dromWrite,
                              .flagUser, .flagPcu, .vmaReg, .vmaLoad);

endmodule

// ==== verif/memAddrUnit_properties.sv ====
// Concurrent checks on the VMA register; bound into memAddrUnit for the load pulse and stall hold
`timescale 1ns/100ps

`include "vma_defs.svh"

module memAddrUnit_properties
(
   input logic               clk,
   input logic               rst,
   input logic               clken,
   input logic               pageFail,
   input logic [`WORD_W-1:0] vmaReg,
   input logic               vmaLoad
);

   // Failed assertion count
   int failCount = 0;

   //////////////////////////////////////////////////
   // Reset and stall behaviour
   //////////////////////////////////////////////////

   // No load pulse straight out of reset
   loadLowAfterReset: assert property (@(posedge clk) rst |=> !vmaLoad)
      else
      begin
         failCount++;
         $error("vmaLoad high in the cycle after reset");
      end

   // Faulting address frozen
   holdOnPageFail: assert property (@(posedge clk) disable iff (rst)
                                    pageFail |=> $stable(vmaReg))
      else
      begin
         failCount++;
         $error("vmaReg changed while pageFail was high");
      end

   // Clock enable low, nothing moves
   holdOnClkenLow: assert property (@(posedge clk) disable iff (rst)
                                    !clken |=> $stable(vmaReg))
      else
      begin
         failCount++;
         $error("vmaReg changed while clken was low");
      end

endmodule

bind memAddrUnit memAddrUnit_properties u_properties (.clk(clk), .rst(rst), .clken(clken),
   .pageFail(pageFail), .vmaReg(vmaReg), .vmaLoad(vmaLoad));

// ==== verif/tb_memAddrUnit.sv ====
// Testbench for the VMA front end; random and directed cycles checked against a cycle model
`timescale 1ns/100ps

`include "vma_defs.svh"

module tb_memAddrUnit
   import vmaPkg::*;
();

   // Reset 16 + random 2000 + five directed phases of 100, plus margin
   localparam int maxCycles     = 3000;
   localparam int randomCycles  = 2000;
   localparam int phaseCycles   = 100;
   // Stimulus shapes
   localparam int phaseRandom   = 0;
   localparam int phaseHold     = 1;
   localparam int phaseARead    = 2;
   localparam int phaseFlags    = 3;
   localparam int phaseClrCache = 4;
   localparam int phaseDpFunc   = 5;

   logic                clk;
   logic                rst;
   logic                clken;
   logic [`UWORD_W-1:0] microWord;
   logic [8:0]          opcode;
   logic [`WORD_W-1:0]  dp;
   logic                cpuExec, prevEn, pageFail, flagLoad, ctxSwitch;
   logic [`WORD_W-1:0]  vmaReg;
   logic                vmaLoad;
   // Model state, current and after the next edge
   logic [`WORD_W-1:0]  modelVma, nextVma;
   logic                modelLoad, nextLoad, modelUser, nextUser, modelPcu, nextPcu;
   int                  cycleCount = 0;

   memAddrUnit u_memAddrUnit (.clk, .rst, .clken, .microWord, .opcode, .dp, .cpuExec,
                              .prevEn, .pageFail, .flagLoad, .ctxSwitch, .vmaReg, .vmaLoad);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Failure reporting
   //////////////////////////////////////////////////

   task automatic stopOnFailure(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compareValue(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
      if (actual !== expected)
         stopOnFailure($sformatf("mismatch at time %0t: %s actual %h expected %h",
                                 $time, name, actual, expected));
   endtask

   // Hang guard
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= maxCycles)
         stopOnFailure("run did not finish within the cycle limit");
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   task automatic predictNext();
      logic [2:0] cls;
      logic       drRead, drWrTest, drWrite, drVma;
      logic       specEn, clr, prevSel, en, men, user;
      cls      = opcode[8:6];
      // Dispatch table by class
      drRead   = (cls == opRead) || (cls == opReadWrite) || (cls == opIo);
      drWrTest = (cls == opReadWrite);
      drWrite  = (cls == opWrite);
      drVma    = (cls == opRead) || (cls == opReadWrite) || (cls == opWrite) || (cls == opJump);
      specEn   = microWord[`U_SPECEN];
      clr      = specEn && (microWord[`U_SPECSEL] == specClrCache);
      prevSel  = specEn && (microWord[`U_SPECSEL] == specPrevious);
      en  = (microWord[`U_MEMCYCLE] && (microWord[`U_LOADVMA] ||
            (microWord[`U_AREAD] && drVma))) || clr;
      men = microWord[`U_MEMCYCLE] && (microWord[`U_WAIT] ||
            (microWord[`U_BWRITE] && drWrite));
      user = (!microWord[`U_FORCEEXEC] && modelUser && !cpuExec) ||
             (microWord[`U_FETCH] && modelUser) || (prevEn && modelPcu) ||
             (prevSel && modelPcu) || microWord[`U_FORCEUSER];
      nextVma  = modelVma;
      nextLoad = en;
      nextUser = modelUser;
      nextPcu  = modelPcu;
      if (clken && en && !pageFail)
      begin
         nextVma[`D_ADDR] = dp[`D_ADDR];
         nextVma[`D_EXTD] = microWord[`U_EXTD];
         // Flags 35:28, user down to iobyte
         if (microWord[`U_DPFUNC])
            nextVma[`D_USER:`D_IOBYTE] = dp[`D_USER:`D_IOBYTE];
         else
            nextVma[`D_USER:`D_IOBYTE] = {user, microWord[`U_FETCH], microWord[`U_PHYS],
                                          prevEn || prevSel, 4'b0000};
      end
      if (clken && men && !pageFail)
      begin
         if (microWord[`U_AREAD])
            nextVma[`D_READ:`D_CACHEINH] = {drRead, drWrTest, drWrite, 1'b0};
         else if (microWord[`U_DPFUNC])
            nextVma[`D_READ:`D_CACHEINH] = dp[`D_READ:`D_CACHEINH];
         else
            nextVma[`D_READ:`D_CACHEINH] = {microWord[`U_READ], microWord[`U_WRTEST],
                                            microWord[`U_WRITE], microWord[`U_CACHEINH]};
      end
      // Flag load beats context switch
      if (clken && flagLoad)
      begin
         nextUser = dp[`D_USER];
         nextPcu  = dp[`D_PREV];
      end
      else if (clken && ctxSwitch)
      begin
         nextPcu  = modelUser;
         nextUser = 1'b0;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic makeStimulus(input int phase, input int idx);
      logic [31:0] ctl;
      logic [31:0] uw;
      logic [31:0] opc;
      logic [31:0] dpLo;
      logic [31:0] dpHi;
      ctl  = $urandom;
      uw   = $urandom;
      opc  = $urandom;
      dpLo = $urandom;
      dpHi = $urandom;
      // Mostly enabled, occasional fault and strobes; memcycle is a plain random bit
      clken         = (ctl[2:0] != 3'd0);
      pageFail      = (ctl[5:3] == 3'd0);
      flagLoad      = (ctl[8:6] == 3'd0);
      ctxSwitch     = (ctl[11:9] == 3'd0);
      cpuExec       = ctl[12];
      prevEn        = ctl[13];
      uw[`U_SPECEN] = (ctl[15:14] == 2'd0);
      opcode        = opc[8:0];
      dp            = {dpHi[3:0], dpLo};
      case (phase)
         phaseHold:
         begin
            // Loads wanted, but mostly blocked
            uw[`U_MEMCYCLE] = 1'b1;
            uw[`U_LOADVMA]  = 1'b1;
            uw[`U_WAIT]     = 1'b1;
            pageFail        = ctl[16];
            clken           = ctl[17];
         end
         phaseARead:
         begin
            // Walk all eight classes
            opcode[8:6]     = idx[2:0];
            uw[`U_MEMCYCLE] = 1'b1;
            uw[`U_AREAD]    = 1'b1;
            uw[`U_LOADVMA]  = 1'b0;
            uw[`U_WAIT]     = 1'b1;
            uw[`U_SPECEN]   = 1'b0;
         end
         phaseFlags:
         begin
            uw[`U_MEMCYCLE] = 1'b1;
            uw[`U_LOADVMA]  = 1'b1;
            uw[`U_DPFUNC]   = 1'b0;
            uw[`U_SPECEN]   = 1'b1;
            uw[`U_SPECSEL]  = ctl[18] ? specPrevious : specNone;
            flagLoad        = ctl[19];
            ctxSwitch       = ctl[20];
         end
         phaseClrCache:
         begin
            // Sweep loads without memcycle
            uw[`U_MEMCYCLE] = 1'b0;
            uw[`U_SPECEN]   = 1'b1;
            uw[`U_SPECSEL]  = specClrCache;
         end
         phaseDpFunc:
         begin
            uw[`U_MEMCYCLE] = 1'b1;
            uw[`U_LOADVMA]  = 1'b1;
            uw[`U_WAIT]     = 1'b1;
            uw[`U_DPFUNC]   = 1'b1;
            uw[`U_AREAD]    = 1'b0;
            uw[`U_SPECEN]   = 1'b0;
         end
         default:
            ;
      endcase
      // Directed phases run unstalled
      if (phase != phaseRandom && phase != phaseHold)
      begin
         clken    = 1'b1;
         pageFail = 1'b0;
      end
      microWord = uw[`UWORD_W-1:0];
   endtask

   // Drive at edge plus 1 ns, check one edge later
   task automatic runCycle(input int phase, input int idx);
      makeStimulus(phase, idx);
      predictNext();
      @(posedge clk);
      #1;
      modelVma  = nextVma;
      modelLoad = nextLoad;
      modelUser = nextUser;
      modelPcu  = nextPcu;
      compareValue("vmaReg", 64'(vmaReg), 64'(modelVma));
      compareValue("vmaLoad", 64'(vmaLoad), 64'(modelLoad));
      compareValue("flagUser", 64'(u_memAddrUnit.flagUser), 64'(modelUser));
      compareValue("flagPcu", 64'(u_memAddrUnit.flagPcu), 64'(modelPcu));
      if (u_memAddrUnit.u_properties.failCount != 0)
         stopOnFailure("a bound assertion on vmaReg or vmaLoad failed");
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      void'($urandom(32'h8c33));
      // Load and flag strobes active throughout reset
      rst       = 1'b1;
      clken     = 1'b1;
      microWord = '1;
      opcode    = '0;
      dp        = '1;
      cpuExec   = 1'b0;
      prevEn    = 1'b0;
      pageFail  = 1'b0;
      flagLoad  = 1'b1;
      ctxSwitch = 1'b0;
      modelVma  = '0;
      modelLoad = 1'b0;
      modelUser = 1'b0;
      modelPcu  = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      // All cleared by reset
      compareValue("vmaReg", 64'(vmaReg), 64'd0);
      compareValue("vmaLoad", 64'(vmaLoad), 64'd0);
      compareValue("flagUser", 64'(u_memAddrUnit.flagUser), 64'd0);
      compareValue("flagPcu", 64'(u_memAddrUnit.flagPcu), 64'd0);
      for (int i = 0; i < randomCycles; i++)
         runCycle(phaseRandom, i);
      for (int p = phaseHold; p <= phaseDpFunc; p++)
         for (int i = 0; i < phaseCycles; i++)
            runCycle(p, i);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+include
hw/vmaPkg.sv
hw/microDecode.sv
hw/dispatchRom.sv
hw/pcFlags.sv
hw/vmaRegister.sv
hw/memAddrUnit.sv
verif/memAddrUnit_properties.sv
verif/tb_memAddrUnit.sv

// ==== Makefile ====
# Verilator build of the VMA front end testbench

TOP = tb_memAddrUnit

.PHONY: all compile run clean

all: run

# Testbench and bound assertions built into one binary
compile:
	verilator --binary --assert --timescale 1ns/100ps -f src.f --top-module $(TOP)

# Output goes to the terminal; pass only when the pass message is found
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
